/* hdl/fll_config.svh */
// Channel count and bus widths of the FLL bank
// Trim level range and the level used after reset or hold
`ifndef FLL_CONFIG_SVH
`define FLL_CONFIG_SVH

`define FLL_CHANNELS    4   // Loop controllers in the bank
`define FLL_DIV_W       5   // Divide ratio per channel

// Clock cycles per reference period, saturates at all ones
`define FLL_CNT_W       8

`define FLL_TRIM_W      26  // Thermometer trim bits, also the top trim level
`define FLL_LEVEL_W     5   // Holds a level from 0 up to 26

// Mid-range start point, half the trim bits on
`define FLL_LEVEL_INIT  13

`endif

/* hdl/fll_pkg.sv */
// Per-channel control struct (sampler to channel)
// Per-channel status struct (channel to encoder)
// Adjust decision and measurement state enums
`default_nettype none

`include "fll_config.svh"

package fll_pkg;

    // Registered control seen by one loop controller
    typedef struct packed {
        logic                  hold;      // Disabled or in DCO mode, level
        logic                  osc_edge;  // Reference rising edge, one cycle
        logic [`FLL_DIV_W-1:0] div;       // Target count per reference period
    } chan_ctl_t;

    // Loop controller result handed to the trim encoder
    typedef struct packed {
        logic [`FLL_LEVEL_W-1:0] level;   // Trim level 0..26
        logic                    locked;  // Last decision was a hold
        logic                    update;  // Level valid for reload
    } chan_stat_t;

    // Step taken on each tracked reference edge
    typedef enum logic [1:0] {
        ADJ_HOLD,
        ADJ_UP,                           // Count above div twice in a row
        ADJ_DOWN                          // Count below div twice in a row
    } adj_t;

    // Two edges are needed before the first full period is known
    typedef enum logic [1:0] {
        ST_WAIT_FIRST,
        ST_WAIT_SECOND,
        ST_TRACK
    } meas_state_t;

endpackage

`default_nettype wire

/* hdl/osc_sampler.sv */
// Reference input synchronizer and rising edge detector
// Builds the registered control struct of every channel
`timescale 1ns/100ps
`default_nettype none

`include "fll_config.svh"

module osc_sampler
    import fll_pkg::*;
(
    input  wire logic                                   clock,
    input  wire logic                                   rst,
    input  wire logic [`FLL_CHANNELS-1:0]               enable,
    input  wire logic [`FLL_CHANNELS-1:0]               dco,
    input  wire logic [`FLL_CHANNELS-1:0]               osc,
    input  wire logic [`FLL_CHANNELS-1:0][`FLL_DIV_W-1:0] div,
    output chan_ctl_t [`FLL_CHANNELS-1:0]               ctl
);

    logic [`FLL_CHANNELS-1:0] osc_s1;   // First sync stage
    logic [`FLL_CHANNELS-1:0] osc_s2;   // Second sync stage, safe to use
    logic [`FLL_CHANNELS-1:0] osc_s3;   // Previous synced value

    // Synchronizer chain and edge pulse
    // A high sampled at edge k shows up as osc_edge after edge k+2
    always_ff @(posedge clock) begin
        if (rst) begin
            osc_s1 <= '0;
            osc_s2 <= '0;
            osc_s3 <= '0;
            for (int i = 0; i < `FLL_CHANNELS; i++) begin
                ctl[i].hold     <= 1'b0;
                ctl[i].osc_edge <= 1'b0;
            end
        end else begin
            osc_s1 <= osc;
            osc_s2 <= osc_s1;
            osc_s3 <= osc_s2;
            for (int i = 0; i < `FLL_CHANNELS; i++) begin
                ctl[i].osc_edge <= osc_s2[i] & ~osc_s3[i];  // Rising edge only
                ctl[i].hold     <= ~enable[i] | dco[i];     // Same role as the internal reset
            end
        end

        // Divide ratio rides along with the edge so a channel sees one consistent struct
        for (int i = 0; i < `FLL_CHANNELS; i++) begin
            ctl[i].div <= div[i];
        end
    end

endmodule

`default_nettype wire

/* hdl/fll_channel.sv */
// One frequency-locked loop controller
// Counts clocks per reference period and steers the trim level
`timescale 1ns/100ps
`default_nettype none

`include "fll_config.svh"

module fll_channel
    import fll_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       rst,
    input  wire chan_ctl_t  ctl,
    output chan_stat_t      stat
);

    localparam logic [`FLL_LEVEL_W-1:0] LEVEL_INIT = `FLL_LEVEL_INIT;
    localparam logic [`FLL_LEVEL_W-1:0] LEVEL_MAX  = `FLL_TRIM_W;    // All trim bits on
    localparam logic [`FLL_CNT_W-1:0]   CNT_ONE    = 1;
    localparam logic [`FLL_CNT_W-1:0]   CNT_MAX    = '1;

    meas_state_t             state;
    adj_t                    adj;        // Decision for the current edge
    logic [`FLL_CNT_W-1:0]   cnt;        // Clocks since last reference edge
    logic [`FLL_CNT_W-1:0]   prev;       // Count of the period before
    logic [`FLL_CNT_W-1:0]   div_ext;    // Divide ratio at counter width
    logic [`FLL_LEVEL_W-1:0] level;
    logic                    locked_q;
    logic                    update_q;

    assign div_ext = {{(`FLL_CNT_W - `FLL_DIV_W){1'b0}}, ctl.div};

    // Two periods on the same side of div are needed to move the level,
    // so a single jittery period does not cause a step
    always_comb begin
        if (cnt > div_ext && prev > div_ext) begin
            adj = ADJ_UP;                // Oscillator too fast
        end else if (cnt < div_ext && prev < div_ext) begin
            adj = ADJ_DOWN;              // Oscillator too slow
        end else begin
            adj = ADJ_HOLD;
        end
    end

    always_ff @(posedge clock) begin
        if (rst || ctl.hold) begin
            state    <= ST_WAIT_FIRST;
            level    <= LEVEL_INIT;
            locked_q <= 1'b0;
            update_q <= 1'b0;
            cnt      <= '0;
        end else begin
            update_q <= ctl.osc_edge;    // Pulse after every evaluated edge

            // The edge cycle is the first clock of the new period
            if (ctl.osc_edge) begin
                cnt <= CNT_ONE;
            end else if (cnt != CNT_MAX) begin
                cnt <= cnt + CNT_ONE;    // Saturate on a very slow reference
            end

            if (ctl.osc_edge) begin
                case (state)
                    ST_WAIT_FIRST:  state <= ST_WAIT_SECOND;  // Count so far is partial
                    ST_WAIT_SECOND: state <= ST_TRACK;        // First full period into prev
                    ST_TRACK: begin
                        locked_q <= (adj == ADJ_HOLD);
                        if (adj == ADJ_UP && level != LEVEL_MAX) begin
                            level <= level + 1'b1;
                        end
                        if (adj == ADJ_DOWN && level != '0) begin
                            level <= level - 1'b1;
                        end
                    end
                    default: state <= ST_WAIT_FIRST;
                endcase
            end
        end
    end

    // Last full period, kept once the second edge has been seen
    always_ff @(posedge clock) begin
        if (ctl.osc_edge && state != ST_WAIT_FIRST) begin
            prev <= cnt;
        end
    end

    // While held the parked level goes out at once, and update asks the
    // encoder to reload it every cycle
    always_comb begin
        stat.level  = ctl.hold ? LEVEL_INIT : level;
        stat.locked = locked_q & ~ctl.hold;
        stat.update = update_q | ctl.hold;
    end

endmodule

`default_nettype wire

/* hdl/trim_encoder.sv */
// Thermometer encoder for the trim levels of all channels
// DCO override with the external trim word, registered lock flags
`timescale 1ns/100ps
`default_nettype none

`include "fll_config.svh"

module trim_encoder
    import fll_pkg::*;
(
    input  wire logic                                      clock,
    input  wire logic                                      rst,
    input  wire chan_stat_t [`FLL_CHANNELS-1:0]            stat,
    input  wire logic [`FLL_CHANNELS-1:0]                  dco,
    input  wire logic [`FLL_CHANNELS-1:0][`FLL_TRIM_W-1:0] ext_trim,
    output logic [`FLL_CHANNELS-1:0][`FLL_TRIM_W-1:0]      trim,
    output logic [`FLL_CHANNELS-1:0]                       locked
);

    localparam logic [`FLL_LEVEL_W-1:0] LEVEL_INIT = `FLL_LEVEL_INIT;

    logic [`FLL_CHANNELS-1:0]                   dco_q;   // Lines up with the sampler delay
    logic [`FLL_CHANNELS-1:0][`FLL_LEVEL_W-1:0] lvl_q;   // Level last applied

    // Lowest lvl bits set, the rest clear
    function automatic logic [`FLL_TRIM_W-1:0] therm(input logic [`FLL_LEVEL_W-1:0] lvl);
        logic [`FLL_TRIM_W-1:0] w;
        for (int b = 0; b < `FLL_TRIM_W; b++) begin
            w[b] = (b < lvl);
        end
        return w;
    endfunction

    always_ff @(posedge clock) begin
        if (rst) begin
            dco_q  <= '0;
            locked <= '0;
            for (int i = 0; i < `FLL_CHANNELS; i++) begin
                lvl_q[i] <= LEVEL_INIT;
                trim[i]  <= therm(LEVEL_INIT);   // Mid-range until the loop moves
            end
        end else begin
            dco_q <= dco;
            for (int i = 0; i < `FLL_CHANNELS; i++) begin
                if (stat[i].update) begin
                    lvl_q[i] <= stat[i].level;
                end
                // New level goes out in the same cycle it is accepted
                if (dco_q[i]) begin
                    trim[i] <= ext_trim[i];      // Ring runs open loop
                end else begin
                    trim[i] <= therm(stat[i].update ? stat[i].level : lvl_q[i]);
                end
                locked[i] <= stat[i].locked & ~dco_q[i];  // No lock in DCO mode
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/fll_bank.sv */
// Top level of the FLL controller bank
// Sampler, one loop controller per channel, trim encoder
`timescale 1ns/100ps
`default_nettype none

`include "fll_config.svh"

module fll_bank
    import fll_pkg::*;
(
    input  wire logic                                      clock,
    input  wire logic                                      rst,
    input  wire logic [`FLL_CHANNELS-1:0]                  enable,
    input  wire logic [`FLL_CHANNELS-1:0]                  dco,
    input  wire logic [`FLL_CHANNELS-1:0]                  osc,
    input  wire logic [`FLL_CHANNELS-1:0][`FLL_DIV_W-1:0]  div,
    input  wire logic [`FLL_CHANNELS-1:0][`FLL_TRIM_W-1:0] ext_trim,
    output logic [`FLL_CHANNELS-1:0][`FLL_TRIM_W-1:0]      trim,
    output logic [`FLL_CHANNELS-1:0]                       locked
);

    chan_ctl_t  [`FLL_CHANNELS-1:0] ctl;    // Sampler to channels
    chan_stat_t [`FLL_CHANNELS-1:0] stat;   // Channels to encoder

    osc_sampler u_sampler (
        .clock  (clock),
        .rst    (rst),
        .enable (enable),
        .dco    (dco),
        .osc    (osc),
        .div    (div),
        .ctl    (ctl)
    );

    // Channels share nothing but the clock and reset
    for (genvar i = 0; i < `FLL_CHANNELS; i++) begin : g_chan
        fll_channel u_chan (
            .clock (clock),
            .rst   (rst),
            .ctl   (ctl[i]),
            .stat  (stat[i])
        );
    end

    trim_encoder u_encoder (
        .clock    (clock),
        .rst      (rst),
        .stat     (stat),
        .dco      (dco),
        .ext_trim (ext_trim),
        .trim     (trim),
        .locked   (locked)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// Free running clock for the FLL bank testbench
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 4          // Full clock period
) (
    output logic clock
);

    // Low at time zero, first rising edge after half a period
    initial begin
        clock = 1'b0;
    end

    always #(PERIOD_NS / 2) clock = ~clock;

endmodule

`default_nettype wire

/* testbench/tb_fll_bank.sv */
// Testbench top for the FLL controller bank
// Plays back the vector file, generates reference waveforms, checks trim and lock
// Watchdog sized from the vector lengths
`timescale 1ns/100ps
`default_nettype none

`include "fll_config.svh"

module tb_fll_bank;

    localparam int CH         = `FLL_CHANNELS;
    localparam int NUM_VEC    = 7;       // Vectors in the data file
    localparam int FIELDS     = 8;       // Values per channel record
    localparam int CLK_PERIOD = 4;       // ns
    localparam int MARGIN     = 40;      // Park, settle and check cycles per vector
    localparam int PAD        = 32 - `FLL_TRIM_W;

    // Column order of one channel record
    localparam int F_EN    = 0;
    localparam int F_DCO   = 1;
    localparam int F_DIV   = 2;
    localparam int F_EXT   = 3;
    localparam int F_PER   = 4;          // Reference period in clock cycles
    localparam int F_EDGES = 5;
    localparam int F_LEVEL = 6;          // Expected trim level
    localparam int F_LOCK  = 7;

    logic                            clock;
    logic                            rst;
    logic [CH-1:0]                   enable;
    logic [CH-1:0]                   dco;
    logic [CH-1:0]                   osc;
    logic [CH-1:0][`FLL_DIV_W-1:0]   div;
    logic [CH-1:0][`FLL_TRIM_W-1:0]  ext_trim;
    logic [CH-1:0][`FLL_TRIM_W-1:0]  trim;
    logic [CH-1:0]                   locked;

    logic [31:0] vec_mem [NUM_VEC*CH*FIELDS];
    logic        loaded = 1'b0;          // Vector memory ready
    integer      seed   = 20;
    int          errors = 0;
    int          checks = 0;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk (.clock(clock));

    fll_bank dut (
        .clock    (clock),
        .rst      (rst),
        .enable   (enable),
        .dco      (dco),
        .osc      (osc),
        .div      (div),
        .ext_trim (ext_trim),
        .trim     (trim),
        .locked   (locked)
    );

    function automatic logic [31:0] vec_field(input int v, input int ch, input int f);
        return vec_mem[(v * CH + ch) * FIELDS + f];
    endfunction

    // Thermometer word with the lowest lvl bits set
    function automatic logic [`FLL_TRIM_W-1:0] ones_word(input int lvl);
        logic [31:0] w;
        w = (32'd1 << lvl) - 32'd1;
        return w[`FLL_TRIM_W-1:0];
    endfunction

    // 50% duty reference, high phase first, edges start after the offset
    function automatic logic ref_level(input int t, input int off, input int per,
                                       input int edg);
        if (t < off || t >= off + per * edg) begin
            return 1'b0;
        end
        return ((t - off) % per) < (per / 2);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // Parks the closed-loop channels, then loads the control inputs of vector v
    task automatic apply_vector(input int v);
        logic [31:0] en_f;
        logic [31:0] dco_f;
        logic [31:0] div_f;
        logic [31:0] ext_f;
        if (v > 0) begin
            @(negedge clock);
            enable = enable & dco;       // Back to level 13, DCO channels held by dco alone
            repeat (4) @(negedge clock);
        end
        @(negedge clock);
        for (int ch = 0; ch < CH; ch++) begin
            en_f  = vec_field(v, ch, F_EN);
            dco_f = vec_field(v, ch, F_DCO);
            div_f = vec_field(v, ch, F_DIV);
            ext_f = vec_field(v, ch, F_EXT);
            enable[ch]   = en_f[0];
            dco[ch]      = dco_f[0];
            div[ch]      = div_f[`FLL_DIV_W-1:0];
            ext_trim[ch] = ext_f[`FLL_TRIM_W-1:0];
        end
        repeat (2) @(negedge clock);     // Hold released before the first edge
    endtask

    // All reference waveforms of one vector, stepped one clock at a time
    task automatic run_refs(input int v);
        int per [CH];
        int edg [CH];
        int off [CH];
        int span;
        span = 0;
        for (int ch = 0; ch < CH; ch++) begin
            per[ch] = int'(vec_field(v, ch, F_PER));
            edg[ch] = int'(vec_field(v, ch, F_EDGES));
            off[ch] = 0;
            if (per[ch] > 0) begin
                off[ch] = $unsigned($random(seed)) % per[ch];  // Random phase
            end
            if (off[ch] + per[ch] * edg[ch] > span) begin
                span = off[ch] + per[ch] * edg[ch];
            end
        end
        for (int t = 0; t < span; t++) begin
            @(negedge clock);
            for (int ch = 0; ch < CH; ch++) begin
                osc[ch] = ref_level(t, off[ch], per[ch], edg[ch]);
            end
        end
        @(negedge clock);
        osc = '0;
    endtask

    task automatic check_vector(input int v);
        logic [31:0]            lvl;
        logic [31:0]            lock_exp;
        logic [31:0]            dco_f;
        logic [31:0]            ext_f;
        logic [`FLL_TRIM_W-1:0] trim_exp;
        for (int ch = 0; ch < CH; ch++) begin
            lvl      = vec_field(v, ch, F_LEVEL);
            lock_exp = vec_field(v, ch, F_LOCK);
            dco_f    = vec_field(v, ch, F_DCO);
            ext_f    = vec_field(v, ch, F_EXT);
            if (dco_f[0]) begin
                trim_exp = ext_f[`FLL_TRIM_W-1:0];   // Open loop, external word
            end else begin
                trim_exp = ones_word(int'(lvl));
            end
            check($sformatf("vec %0d trim[%0d]", v, ch),
                  {{PAD{1'b0}}, trim[ch]}, {{PAD{1'b0}}, trim_exp});
            check($sformatf("vec %0d locked[%0d]", v, ch), {31'd0, locked[ch]}, lock_exp);
        end
    endtask

    initial begin
        rst      = 1'b1;
        enable   = '1;
        dco      = '0;
        osc      = '0;
        div      = '0;
        ext_trim = '0;
        $readmemh("testbench/fll_input.txt", vec_mem);
        loaded = 1'b1;
        repeat (4) @(negedge clock);
        rst = 1'b0;
        for (int v = 0; v < NUM_VEC; v++) begin
            apply_vector(v);
            run_refs(v);
            repeat (6) @(negedge clock); // Sampler, channel and encoder latency
            check_vector(v);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Twice the expected run length, in clock cycles
    initial begin : watchdog
        int budget;
        int span;
        wait (loaded);
        budget = 8;                      // Reset and slack
        for (int v = 0; v < NUM_VEC; v++) begin
            span = 0;
            for (int ch = 0; ch < CH; ch++) begin
                if (int'(vec_field(v, ch, F_PER)) * (int'(vec_field(v, ch, F_EDGES)) + 1)
                        > span) begin
                    span = int'(vec_field(v, ch, F_PER))
                           * (int'(vec_field(v, ch, F_EDGES)) + 1);
                end
            end
            budget += span + MARGIN;
        end
        #(budget * CLK_PERIOD * 2);
        $display("Timeout: the run did not finish within %0d clock cycles", budget * 2);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/fll_input.txt */
// One line per channel, hex: enable dco div ext_trim period edges level locked
// Four lines make one vector, channel 0 first; level is the expected trim level
// Vector 0, after reset with no reference edges
1 0 0A 0000000 10 00 0D 0
1 0 0A 0000000 10 00 0D 0
1 0 0A 0000000 10 00 0D 0
1 0 0A 0000000 10 00 0D 0
// Vector 1, period above div so the level rises
1 0 08 0000000 0C 06 11 0
1 0 06 0000000 0A 05 10 0
1 0 10 0000000 14 04 0F 0
1 0 04 0000000 08 03 0E 0
// Vector 2, saturation at 26 and at 0
1 0 04 0000000 06 12 1A 0
1 0 03 0000000 05 10 1A 0
1 0 14 0000000 08 12 00 0
1 0 1F 0000000 06 14 00 0
// Vector 3, period below div so the level falls
1 0 10 0000000 0C 05 0A 0
1 0 0C 0000000 08 06 09 0
1 0 1E 0000000 14 04 0B 0
1 0 09 0000000 06 03 0C 0
// Vector 4, period equal to div, lock after the third edge
1 0 08 0000000 08 05 0D 1
1 0 0C 0000000 0C 03 0D 1
1 0 10 0000000 10 02 0D 0
1 0 06 0000000 06 04 0D 1
// Vector 5, DCO mode on channels 0 and 2
1 1 08 2AAAAAA 0C 06 0D 0
1 0 08 0000000 0C 06 11 0
1 1 10 0000FFF 10 05 0D 0
1 0 06 0000000 06 05 0D 1
// Vector 6, DCO cleared on channel 0, channels 1 and 3 disabled
1 0 08 2AAAAAA 0C 04 0F 0
0 0 08 0000000 0C 06 0D 0
1 0 10 0000000 0A 05 0A 0
0 0 06 0000000 06 05 0D 0

/* list.f */
+incdir+hdl
hdl/fll_pkg.sv
hdl/osc_sampler.sv
hdl/fll_channel.sv
hdl/trim_encoder.sv
hdl/fll_bank.sv
testbench/tb_clock_gen.sv
testbench/tb_fll_bank.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the FLL bank testbench with Verilator and run it
# Exit status is 0 only when the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
        --top-module tb_fll_bank -f list.f \
    && { out="$(./obj_dir/Vtb_fll_bank)"; echo "$out"; \
         echo "$out" | grep -q "TESTS PASSED"; } \
    && exit 0 \
    || exit 1
